// ==== rtl/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// --------------------
// Prefetch queue sizing
// --------------------

// Entries in the prefetch FIFO, power of two from 4 up
`define FETCH_FIFO_DEPTH 8

// Free entries needed to start a burst, one per possible beat
`define FETCH_ROOM_MIN 4

// --------------------
// Length widths
// --------------------

`define FETCH_LEN_W 5 // Request length 0 to 16
`define FETCH_CNT_W 3 // Entry byte count 0 to 4

`endif

// ==== rtl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

   // --------------------
   // Code word views
   // --------------------

   // One memory dword as the producer sees it,
   // or four code bytes as the aligner picks them
   typedef union packed {
      logic [31:0]      dword; // Whole beat, shifted by byte offset
      logic [3:0][7:0]  bytes; // Byte 0 is the lowest address
   } code_word_u;

endpackage

`default_nettype wire

// ==== rtl/fetch_burst_plan.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module fetch_burst_plan (
   input  wire logic [31:0]               addr,
   input  wire logic [`FETCH_LEN_W-1:0]   len,
   input  wire logic [1:0]                beat_idx,
   input  wire logic [31:0]               beat_data,
   output fetch_pkg::code_word_u          beat_word,
   output logic [`FETCH_CNT_W-1:0]        beat_cnt,
   output logic                           last_beat
);

   localparam int LW = `FETCH_LEN_W;
   localparam int CW = `FETCH_CNT_W;

   logic [1:0]    off;        // Byte offset in first dword
   logic [2:0]    nbeats;     // Dwords up to line end, 1 to 4
   logic          in_line;    // Beat lies inside the burst
   logic [2:0]    nominal;    // Bytes this beat could carry
   logic [2:0]    nom_cnt;
   logic [LW-1:0] used;       // Bytes taken by earlier beats
   logic [LW-1:0] left;       // Bytes of len still wanted

   // --------------------
   // Burst shape
   // --------------------

   assign off     = addr[1:0];
   assign nbeats  = 3'd4 - {1'b0, addr[3:2]};
   assign in_line = {1'b0, beat_idx} < nbeats;

   always_comb begin
      if (beat_idx == 2'd0) begin
         used    = '0;
         nominal = 3'd4 - {1'b0, off}; // Partial first dword
      end else begin
         // First beat plus whole dwords in between
         used    = LW'(3'd4 - {1'b0, off}) + LW'({beat_idx - 2'd1, 2'b00});
         nominal = 3'd4;
      end
   end

   // --------------------
   // Byte count for this beat
   // --------------------

   assign left    = (len > used) ? len - used : '0;
   assign nom_cnt = in_line ? nominal : 3'd0;

   // Cap by remaining request length
   assign beat_cnt = (LW'(nom_cnt) > left) ? CW'(left) : CW'(nom_cnt);

   // Final beat that still carries bytes
   assign last_beat = (beat_cnt != '0) &&
                      ((LW'(beat_cnt) == left) || ({1'b0, beat_idx} == nbeats - 3'd1));

   // --------------------
   // Data alignment
   // --------------------

   always_comb begin
      if (beat_idx == 2'd0)
         beat_word.dword = beat_data >> {off, 3'b000}; // Wanted bytes to byte 0
      else
         beat_word.dword = beat_data;
   end

endmodule

`default_nettype wire

// ==== rtl/code_fetch.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module code_fetch (
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   // Request side
   input  wire logic                      fetch_req,
   input  wire logic [31:0]               fetch_addr,
   input  wire logic [`FETCH_LEN_W-1:0]   fetch_len,
   input  wire logic                      flush,
   output logic                           fetch_busy,
   input  wire logic                      room,
   // Memory side
   output logic                           mem_req,
   output logic [31:0]                    mem_addr,
   input  wire logic [31:0]               mem_partial_data,
   input  wire logic                      mem_partial_done,
   input  wire logic                      mem_done,
   // FIFO write side
   output logic                           wr_en,
   output fetch_pkg::code_word_u          wr_data,
   output logic [`FETCH_CNT_W-1:0]        wr_cnt
);

   localparam logic ST_IDLE = 1'b0;
   localparam logic ST_READ = 1'b1;

   logic                      state;
   logic [31:0]               addr_q;        // Latched request address
   logic [`FETCH_LEN_W-1:0]   len_q;         // Latched request length
   logic [1:0]                beat_idx;
   logic                      flush_pend;    // Flush seen mid burst
   logic                      accept;
   logic                      beat;
   logic [31:0]               plan_addr;
   logic [`FETCH_LEN_W-1:0]   plan_len;
   fetch_pkg::code_word_u     beat_word;
   logic [`FETCH_CNT_W-1:0]   beat_cnt;

   // --------------------
   // Request acceptance
   // --------------------

   assign accept = (state == ST_IDLE) && fetch_req && room && !flush &&
                   (fetch_len != '0);

   assign fetch_busy = (state != ST_IDLE) || !room;
   assign mem_req    = accept;                       // Pulse in acceptance cycle
   assign mem_addr   = {fetch_addr[31:2], 2'b00};    // Dword aligned start

   assign beat = mem_partial_done || mem_done;

   // Live request while idle, latched one while reading
   assign plan_addr = (state == ST_IDLE) ? fetch_addr : addr_q;
   assign plan_len  = (state == ST_IDLE) ? fetch_len : len_q;

   fetch_burst_plan u_plan (
      .addr       (plan_addr),
      .len        (plan_len),
      .beat_idx   (beat_idx),
      .beat_data  (mem_partial_data),
      .beat_word  (beat_word),
      .beat_cnt   (beat_cnt),
      .last_beat  ()
   );

   // --------------------
   // FIFO write
   // --------------------

   // Beats past the request length plan zero bytes
   assign wr_en = (state == ST_READ) && beat && (beat_cnt != '0) &&
                  !flush && !flush_pend;
   assign wr_data = beat_word;
   assign wr_cnt  = beat_cnt;

   // --------------------
   // State machine
   // --------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= ST_IDLE;
         beat_idx   <= 2'd0;
         flush_pend <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               flush_pend <= 1'b0;
               if (accept) begin
                  state     <= ST_READ;
                  beat_idx  <= 2'd0;
               end
            end
            default: begin
               if (beat)
                  beat_idx <= beat_idx + 2'd1;
               if (mem_done) begin
                  state      <= ST_IDLE;
                  flush_pend <= 1'b0;
               end else if (flush) begin
                  flush_pend <= 1'b1; // Drop remaining beats
               end
            end
         endcase
      end
   end

   // Request payload
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q <= fetch_addr;
         len_q  <= fetch_len;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/prefetch_fifo.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module prefetch_fifo (
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   input  wire logic                      flush,
   // Write side
   input  wire logic                      wr_en,
   input  wire fetch_pkg::code_word_u     wr_data,
   input  wire logic [`FETCH_CNT_W-1:0]   wr_cnt,
   output logic                           room,
   // Read side
   input  wire logic                      rd_en,
   output fetch_pkg::code_word_u          rd_data,
   output logic [`FETCH_CNT_W-1:0]        rd_cnt,
   output logic                           empty
);

   localparam int DEPTH = `FETCH_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);
   localparam int NW    = AW + 1;

   fetch_pkg::code_word_u     data_mem [DEPTH];
   logic [`FETCH_CNT_W-1:0]   cnt_mem  [DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [NW-1:0] count;      // Occupied entries
   logic [NW-1:0] free_cnt;
   logic          full;
   logic          do_wr;
   logic          do_rd;

   // --------------------
   // Status
   // --------------------

   assign empty    = (count == '0);
   assign full     = (count == NW'(DEPTH));
   assign free_cnt = NW'(DEPTH) - count;
   assign room     = free_cnt >= NW'(`FETCH_ROOM_MIN); // Space for a whole burst

   assign do_wr = wr_en && !full && !flush;
   assign do_rd = rd_en && !empty && !flush;

   // Show-ahead read port
   assign rd_data = data_mem[rd_ptr];
   assign rd_cnt  = cnt_mem[rd_ptr];

   // --------------------
   // Pointers and count
   // --------------------

   always_ff @(posedge clk) begin
      if (!rst_n || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + AW'(1); // Wraps at depth
         if (do_rd)
            rd_ptr <= rd_ptr + AW'(1);
         case ({do_wr, do_rd})
            2'b10:   count <= count + NW'(1);
            2'b01:   count <= count - NW'(1);
            default: count <= count;
         endcase
      end
   end

   // Entry storage
   always_ff @(posedge clk) begin
      if (do_wr) begin
         data_mem[wr_ptr] <= wr_data;
         cnt_mem[wr_ptr]  <= wr_cnt;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/prefetch_align.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module prefetch_align (
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   input  wire logic                      flush,
   // FIFO side
   input  wire logic                      empty,
   input  wire fetch_pkg::code_word_u     rd_data,
   input  wire logic [`FETCH_CNT_W-1:0]   rd_cnt,
   output logic                           rd_en,
   // Decoder side
   output logic                           code_valid,
   output logic [7:0]                     code_byte,
   input  wire logic                      code_ready
);

   fetch_pkg::code_word_u     word_q;     // Held entry
   logic [`FETCH_CNT_W-1:0]   left_q;     // Bytes still to hand out
   logic [1:0]                idx_q;      // Next byte in the entry
   logic                      valid_q;
   logic                      xfer;
   logic                      last_xfer;

   // --------------------
   // Byte output
   // --------------------

   assign code_valid = valid_q;
   assign code_byte  = word_q.bytes[idx_q];

   assign xfer      = valid_q && code_ready;
   assign last_xfer = xfer && (left_q == `FETCH_CNT_W'(1));

   // Load when idle or as the last byte leaves
   assign rd_en = !empty && !flush && (!valid_q || last_xfer);

   // --------------------
   // Entry tracking
   // --------------------

   always_ff @(posedge clk) begin
      if (!rst_n || flush) begin
         valid_q <= 1'b0;
         left_q  <= '0;
         idx_q   <= 2'd0;
      end else if (rd_en) begin
         valid_q <= (rd_cnt != '0);
         left_q  <= rd_cnt;
         idx_q   <= 2'd0;
      end else if (xfer) begin
         left_q  <= left_q - `FETCH_CNT_W'(1);
         idx_q   <= idx_q + 2'd1;
         if (last_xfer)
            valid_q <= 1'b0; // Entry used up with nothing to reload
      end
   end

   // Entry data
   always_ff @(posedge clk) begin
      if (rd_en)
         word_q <= rd_data;
   end

endmodule

`default_nettype wire

// ==== rtl/fetch_top.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module fetch_top (
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   // Request side
   input  wire logic                      fetch_req,
   input  wire logic [31:0]               fetch_addr,
   input  wire logic [`FETCH_LEN_W-1:0]   fetch_len,
   input  wire logic                      flush,
   output logic                           fetch_busy,
   // Memory side
   output logic                           mem_req,
   output logic [31:0]                    mem_addr,
   input  wire logic [31:0]               mem_partial_data,
   input  wire logic                      mem_partial_done,
   input  wire logic                      mem_done,
   // Decoder side
   output logic                           code_valid,
   output logic [7:0]                     code_byte,
   input  wire logic                      code_ready
);

   // --------------------
   // Internal links
   // --------------------

   logic                      wr_en;
   fetch_pkg::code_word_u     wr_data;
   logic [`FETCH_CNT_W-1:0]   wr_cnt;
   logic                      room;
   logic                      rd_en;
   fetch_pkg::code_word_u     rd_data;
   logic [`FETCH_CNT_W-1:0]   rd_cnt;
   logic                      empty;

   // Producer, bursts into the queue
   code_fetch u_fetch (
      .clk              (clk),
      .rst_n            (rst_n),
      .fetch_req        (fetch_req),
      .fetch_addr       (fetch_addr),
      .fetch_len        (fetch_len),
      .flush            (flush),
      .fetch_busy       (fetch_busy),
      .room             (room),
      .mem_req          (mem_req),
      .mem_addr         (mem_addr),
      .mem_partial_data (mem_partial_data),
      .mem_partial_done (mem_partial_done),
      .mem_done         (mem_done),
      .wr_en            (wr_en),
      .wr_data          (wr_data),
      .wr_cnt           (wr_cnt)
   );

   prefetch_fifo u_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush   (flush),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .wr_cnt  (wr_cnt),
      .room    (room),
      .rd_en   (rd_en),
      .rd_data (rd_data),
      .rd_cnt  (rd_cnt),
      .empty   (empty)
   );

   // Consumer, one byte per decoder cycle
   prefetch_align u_align (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .empty      (empty),
      .rd_data    (rd_data),
      .rd_cnt     (rd_cnt),
      .rd_en      (rd_en),
      .code_valid (code_valid),
      .code_byte  (code_byte),
      .code_ready (code_ready)
   );

endmodule

`default_nettype wire

// ==== tests/fetch_checker.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module fetch_checker (
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   input  wire logic                      fetch_req,
   input  wire logic [31:0]               fetch_addr,
   input  wire logic [`FETCH_LEN_W-1:0]   fetch_len,
   input  wire logic                      flush,
   input  wire logic                      fetch_busy,
   input  wire logic                      mem_req,
   input  wire logic [31:0]               mem_addr,
   input  wire logic                      code_valid,
   input  wire logic [7:0]                code_byte,
   input  wire logic                      code_ready,
   output int                             pending,
   output int                             mismatches,
   output int                             other_errs
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [7:0]    exp_q [$];     // Expected code bytes in order
   string         name_q [$];    // Row that queued each byte
   string         cur_test = "none";
   int            n_pend = 0;
   int            n_mis = 0;
   int            n_oth = 0;
   logic          accept_now;
   logic [7:0]    exp_b;
   string         exp_n;

   assign pending    = n_pend;
   assign mismatches = n_mis;
   assign other_errs = n_oth;

   task automatic set_test(input string name);
      cur_test = name;
   endtask

   // Bytes from addr up to addr plus len, cut at the 16-byte line end
   function automatic void push_expected(input logic [31:0] addr,
                                         input logic [`FETCH_LEN_W-1:0] len);
      logic [31:0] line_end;
      logic [31:0] stop;
      logic [31:0] a;
      line_end = {addr[31:4], 4'h0} + 32'd16;
      stop     = addr + 32'(len);
      if (stop > line_end)
         stop = line_end;
      for (a = addr; a < stop; a = a + 32'd1) begin
         exp_q.push_back(a[7:0] ^ 8'h5a); // Same fill as memory
         name_q.push_back(cur_test);
      end
   endfunction

   // --------------------
   // Port watch at mid cycle
   // --------------------

   always @(negedge clk) begin
      if (rst_n) begin
         accept_now = fetch_req && !fetch_busy && !flush && (fetch_len != '0);
         if (mem_req !== accept_now) begin
            n_oth++;
            $display("memory request was %b in %s where the request rule gives %b",
                     mem_req, cur_test, accept_now);
         end else if (mem_req && (mem_addr !== {fetch_addr[31:2], 2'b00})) begin
            n_oth++;
            $display("memory address %08h in %s is not the dword of %08h",
                     mem_addr, cur_test, fetch_addr);
         end
         if (flush) begin
            exp_q.delete(); // Whole burst discarded
            name_q.delete();
         end else if (code_valid && code_ready) begin
            if (exp_q.size() == 0) begin
               n_oth++;
               $display("code byte %02h arrived with nothing expected, last test %s",
                        code_byte, cur_test);
            end else begin
               exp_b = exp_q.pop_front();
               exp_n = name_q.pop_front();
               if (code_byte !== exp_b) begin
                  n_mis++;
                  $display("mismatch %s: expected %02h, actual %02h",
                           exp_n, exp_b, code_byte);
               end
            end
         end
         if (accept_now)
            push_expected(fetch_addr, fetch_len);
         n_pend = exp_q.size();
      end
   end

endmodule

`default_nettype wire

// ==== tests/fetch_tb.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          TIMEOUT_CYC = 2000;
   localparam logic [31:0] LFSR_SEED   = 32'h82f9_a925;

   logic                      clk = 1'b0;
   logic                      rst_n;
   logic                      fetch_req;
   logic [31:0]               fetch_addr;
   logic [`FETCH_LEN_W-1:0]   fetch_len;
   logic                      flush;
   logic                      fetch_busy;
   logic                      mem_req;
   logic [31:0]               mem_addr;
   logic [31:0]               mem_partial_data;
   logic                      mem_partial_done;
   logic                      mem_done;
   logic                      code_valid;
   logic [7:0]                code_byte;
   logic                      code_ready;
   int                        pending;
   int                        mismatches;
   int                        other_errs;
   int                        tb_errs = 0;      // Timeouts and lost bytes
   int                        ready_mode = 0;   // 0 always, 1 half, 2 quarter
   int                        beats_done;       // Beats taken in current burst

   // --------------------
   // Stimulus table
   // --------------------

   string                     row_name [$];
   logic [31:0]               row_addr [$];
   logic [`FETCH_LEN_W-1:0]   row_len [$];
   int                        row_flush [$];    // Beats before flush or -1 for none
   int                        row_ready [$];
   int                        row_hold [$];     // Cycles fetch_req stays high
   bit                        row_b2b [$];      // Next row without draining

   always #2 clk = ~clk;

   fetch_top dut (.*);

   fetch_checker chk (.*);

   function automatic logic lfsr_bit(inout logic [31:0] state);
      logic out;
      out   = state[0];
      state = state >> 1;
      if (out)
         state = state ^ 32'h8020_0003; // Galois taps
      return out;
   endfunction

   // Byte at address A holds A[7:0] ^ 8'h5a
   function automatic logic [31:0] mem_word(input logic [31:0] daddr);
      logic [31:0] w;
      for (int j = 0; j < 4; j++)
         w[j*8 +: 8] = (daddr[7:0] + 8'(j)) ^ 8'h5a;
      return w;
   endfunction

   task automatic add_row(input string name, input logic [31:0] addr,
                          input logic [`FETCH_LEN_W-1:0] len, input int flush_after,
                          input int ready, input int hold, input bit b2b);
      row_name.push_back(name);
      row_addr.push_back(addr);
      row_len.push_back(len);
      row_flush.push_back(flush_after);
      row_ready.push_back(ready);
      row_hold.push_back(hold);
      row_b2b.push_back(b2b);
   endtask

   task automatic next_drive();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_idle(input string name);
      int n;
      n = 0;
      next_drive();
      while (fetch_busy && n < TIMEOUT_CYC) begin
         next_drive();
         n++;
      end
      if (fetch_busy) begin
         tb_errs++;
         $display("timeout in %s: fetch_busy stayed high", name);
      end
   endtask

   task automatic wait_drain(input string name);
      int n;
      n = 0;
      while ((pending != 0 || code_valid || fetch_busy) && n < TIMEOUT_CYC) begin
         next_drive();
         n++;
      end
      if (pending != 0 || code_valid || fetch_busy) begin
         tb_errs++;
         $display("timeout in %s: %0d code bytes never drained", name, pending);
      end
   endtask

   task automatic wait_beats(input int beats, input string name);
      int n;
      n = 0;
      while (beats_done < beats && n < TIMEOUT_CYC) begin
         next_drive();
         n++;
      end
      if (beats_done < beats) begin
         tb_errs++;
         $display("timeout in %s: memory beat %0d never came", name, beats);
      end
   endtask

   // --------------------
   // Memory model
   // --------------------

   initial begin : mem_model
      logic [31:0] lfsr;
      logic [31:0] base;
      int          nb;
      int          lat;
      lfsr             = LFSR_SEED;
      mem_partial_data = '0;
      mem_partial_done = 1'b0;
      mem_done         = 1'b0;
      beats_done       = 0;
      forever begin
         @(negedge clk);
         if (rst_n === 1'b1 && mem_req === 1'b1) begin
            base = mem_addr;
            nb   = 4 - int'(mem_addr[3:2]); // Dwords to line end
            lat  = 1;
            if (lfsr_bit(lfsr))
               lat += 2;
            if (lfsr_bit(lfsr))
               lat += 1;
            beats_done = 0;
            @(posedge clk); // Acceptance edge
            repeat (lat - 1) @(posedge clk);
            for (int b = 0; b < nb; b++) begin
               #1;
               mem_partial_data = mem_word(base + 32'(4 * b));
               mem_partial_done = 1'b1;
               mem_done         = (b == nb - 1);
               @(posedge clk);
               beats_done = b + 1;
            end
            #1;
            mem_partial_done = 1'b0;
            mem_done         = 1'b0;
         end
      end
   end

   // Decoder ready pattern
   initial begin : ready_drive
      logic [31:0] lfsr;
      int          mode;
      lfsr       = LFSR_SEED;
      code_ready = 1'b0;
      forever begin
         @(posedge clk);
         mode = ready_mode; // Row mode as it stood at the edge
         #1;
         case (mode)
            0:       code_ready = 1'b1;
            1:       code_ready = lfsr_bit(lfsr);
            default: code_ready = lfsr_bit(lfsr) & lfsr_bit(lfsr);
         endcase
      end
   end

   // --------------------
   // Row loop
   // --------------------

   initial begin : main
      rst_n      = 1'b0;
      fetch_req  = 1'b0;
      fetch_addr = '0;
      fetch_len  = '0;
      flush      = 1'b0;
      add_row("aligned_full",    32'h0000_1000, 5'd16, -1, 0, 1, 1'b0);
      add_row("offset3",         32'h0000_2013, 5'd16, -1, 0, 1, 1'b0);
      add_row("short_len",       32'h0000_3024, 5'd5,  -1, 0, 1, 1'b0);
      add_row("short_unaligned", 32'h0000_304a, 5'd3,  -1, 1, 1, 1'b0);
      add_row("b2b_0",           32'h0000_4100, 5'd16, -1, 2, 1, 1'b1);
      add_row("b2b_1",           32'h0000_4117, 5'd9,  -1, 2, 1, 1'b1);
      add_row("b2b_2",           32'h0000_4121, 5'd16, -1, 1, 1, 1'b1);
      add_row("b2b_3",           32'h0000_4138, 5'd16, -1, 1, 1, 1'b0);
      add_row("flush_mid",       32'h0000_5000, 5'd16,  2, 1, 1, 1'b0);
      add_row("after_flush",     32'h0000_5042, 5'd12, -1, 0, 1, 1'b0);
      add_row("zero_len",        32'h0000_6000, 5'd0,  -1, 0, 1, 1'b0);
      add_row("req_while_busy",  32'h0000_7008, 5'd8,  -1, 0, 3, 1'b0);
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int i = 0; i < row_name.size(); i++) begin
         wait_idle(row_name[i]);
         chk.set_test(row_name[i]);
         ready_mode = row_ready[i];
         fetch_addr = row_addr[i];
         fetch_len  = row_len[i];
         fetch_req  = 1'b1;
         repeat (row_hold[i]) next_drive(); // Later cycles meet a busy unit
         fetch_req  = 1'b0;
         if (row_flush[i] >= 0) begin
            wait_beats(row_flush[i], row_name[i]);
            flush = 1'b1;
            next_drive();
            flush = 1'b0;
         end
         if (!row_b2b[i])
            wait_drain(row_name[i]);
      end
      if (pending != 0) begin
         tb_errs++;
         $display("%0d expected code bytes never arrived", pending);
      end
      $display("errors: %0d mismatch, %0d checker, %0d testbench",
               mismatches, other_errs, tb_errs);
      if (mismatches + other_errs + tb_errs == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_burst_plan.sv
rtl/code_fetch.sv
rtl/prefetch_fifo.sv
rtl/prefetch_align.sv
rtl/fetch_top.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
   -f files.f --top-module fetch_tb -o fetch_sim

./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
   exit 1
fi
exit 0
